// File: hdl/dflate_hdr_pkg.sv
//----------------------------------------
// Shared types and constants for the zlib / raw deflate header parser.
// Referenced by scoped name from every RTL file.
//----------------------------------------
package dflate_hdr_pkg;

   localparam int hdr_word_w = 64;
   localparam int len_w      = 16;
   localparam int bits_w     = 7;
   localparam int fmt_w      = 2;
   localparam int err_w      = 4;

   // stored doubles as the format reported on any error.
   localparam logic [fmt_w-1:0] fmt_stored  = 2'd0;
   localparam logic [fmt_w-1:0] fmt_fixed   = 2'd1;
   localparam logic [fmt_w-1:0] fmt_dynamic = 2'd2;

   localparam logic [1:0] btype_stored   = 2'd0;
   localparam logic [1:0] btype_fixed    = 2'd1;
   localparam logic [1:0] btype_dynamic  = 2'd2;
   localparam logic [1:0] btype_reserved = 2'd3;

   localparam logic [err_w-1:0] err_none        = 4'd0;
   localparam logic [err_w-1:0] err_cm          = 4'd1;
   localparam logic [err_w-1:0] err_cinfo       = 4'd2;
   localparam logic [err_w-1:0] err_fcheck      = 4'd3;
   localparam logic [err_w-1:0] err_hdr_invalid = 4'd4;
   localparam logic [err_w-1:0] err_fdict       = 4'd5;
   localparam logic [err_w-1:0] err_len_check   = 4'd6;

   localparam logic [3:0]  zlib_cm_deflate = 4'd8;
   localparam logic [3:0]  zlib_cinfo_max  = 4'd7;   // 32k window needs an exact match.
   localparam logic [15:0] zlib_fcheck_mod = 16'd31;

   localparam logic [bits_w-1:0] zlib_bits_coded  = 7'd19;
   localparam logic [bits_w-1:0] zlib_bits_stored = 7'd56;
   localparam logic [bits_w-1:0] raw_bits_coded   = 7'd3;
   localparam logic [bits_w-1:0] raw_bits_stored  = 7'd40;

   // first word of a frame, seen either through the zlib or the raw framing.
   typedef union packed {
      struct packed {
         logic [7:0]       unused;
         logic [len_w-1:0] nlen;
         logic [len_w-1:0] len;
         logic [4:0]       reserved;   // stored block pad to byte boundary.
         logic [1:0]       btype;
         logic             bfinal;
         logic [7:0]       flg;
         logic [7:0]       cmf;        // cinfo in the high nibble, cm low.
      } zlib;
      struct packed {
         logic [23:0]      unused;
         logic [len_w-1:0] nlen;
         logic [len_w-1:0] len;
         logic [4:0]       padding;
         logic [1:0]       btype;
         logic             bfinal;
      } raw;
   } dflate_hdr_word_u;

endpackage

// File: hdl/hdr_fields_if.sv
//----------------------------------------
// Decoded header fields passed from the decode stage to the
// status encode stage under a valid/ready handshake.
//----------------------------------------
`timescale 1ns/1ps

interface hdr_fields_if;

   logic                              valid;
   logic                              ready;
   logic [1:0]                        btype;
   logic                              bfinal;
   logic [dflate_hdr_pkg::len_w-1:0]  len;
   logic [dflate_hdr_pkg::bits_w-1:0] bits;
   logic                              cm_err;
   logic                              cinfo_err;
   logic                              fcheck_err;
   logic                              fdict;
   logic                              len_err;

   modport producer (
      output valid, btype, bfinal, len, bits,
      output cm_err, cinfo_err, fcheck_err, fdict, len_err,
      input  ready
   );

   modport consumer (
      input  valid, btype, bfinal, len, bits,
      input  cm_err, cinfo_err, fcheck_err, fdict, len_err,
      output ready
   );

endinterface

// File: hdl/hdr_field_decode.sv
//----------------------------------------
// Stage 1: takes the sof word of each frame, decodes and checks the
// header fields and holds them until stage 2 accepts them.
//----------------------------------------
`timescale 1ns/1ps

module hdr_field_decode (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [dflate_hdr_pkg::hdr_word_w-1:0] in_data,
   input  logic                                  in_sof,
   input  logic                                  in_zlib,
   input  logic                                  in_valid,
   output logic                                  in_ready,
   hdr_fields_if.producer                        fields
);

   dflate_hdr_pkg::dflate_hdr_word_u  hdr;
   logic                              hdr_take;
   logic                              nxt_bfinal;
   logic [1:0]                        nxt_btype;
   logic [dflate_hdr_pkg::len_w-1:0]  nxt_len;
   logic [dflate_hdr_pkg::len_w-1:0]  nxt_nlen;
   logic                              nxt_stored;
   logic                              nxt_len_err;
   logic [dflate_hdr_pkg::bits_w-1:0] nxt_bits;
   logic [3:0]                        zlib_cm;
   logic [3:0]                        zlib_cinfo;
   logic [15:0]                       zlib_fcheck;
   logic                              nxt_cm_err;
   logic                              nxt_cinfo_err;
   logic                              nxt_fcheck_err;
   logic                              nxt_fdict;

   assign hdr = in_data;

   // payload words are always taken, sof words need a free slot.
   assign in_ready = !in_sof || !fields.valid || fields.ready;
   assign hdr_take = in_valid && in_ready && in_sof;

   always_comb begin
      if (in_zlib) begin
         nxt_bfinal = hdr.zlib.bfinal;
         nxt_btype  = hdr.zlib.btype;
         nxt_len    = hdr.zlib.len;
         nxt_nlen   = hdr.zlib.nlen;
      end
      else begin
         nxt_bfinal = hdr.raw.bfinal;
         nxt_btype  = hdr.raw.btype;
         nxt_len    = hdr.raw.len;
         nxt_nlen   = hdr.raw.nlen;
      end
   end

   assign nxt_stored  = (nxt_btype == dflate_hdr_pkg::btype_stored);
   assign nxt_len_err = nxt_stored && (nxt_len != ~nxt_nlen);   // nlen is one's complement.

   always_comb begin
      case ({in_zlib, nxt_stored})
         2'b11:   nxt_bits = dflate_hdr_pkg::zlib_bits_stored;
         2'b10:   nxt_bits = dflate_hdr_pkg::zlib_bits_coded;
         2'b01:   nxt_bits = dflate_hdr_pkg::raw_bits_stored;
         default: nxt_bits = dflate_hdr_pkg::raw_bits_coded;
      endcase
   end

   // zlib only checks on the CMF/FLG pair.
   assign zlib_cm     = hdr.zlib.cmf[3:0];
   assign zlib_cinfo  = hdr.zlib.cmf[7:4];
   assign zlib_fcheck = {hdr.zlib.cmf, hdr.zlib.flg} % dflate_hdr_pkg::zlib_fcheck_mod;

   assign nxt_cm_err     = in_zlib && (zlib_cm != dflate_hdr_pkg::zlib_cm_deflate);
   assign nxt_cinfo_err  = in_zlib && (zlib_cinfo != dflate_hdr_pkg::zlib_cinfo_max);
   assign nxt_fcheck_err = in_zlib && (zlib_fcheck != 16'd0);
   assign nxt_fdict      = in_zlib && hdr.zlib.flg[5];   // word bit 13.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fields.valid <= 1'b0;
      end
      else if (hdr_take) begin
         fields.valid <= 1'b1;
      end
      else if (fields.ready) begin
         fields.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_take) begin
         fields.bfinal     <= nxt_bfinal;
         fields.btype      <= nxt_btype;
         fields.len        <= nxt_stored ? nxt_len : '0;
         fields.len_err    <= nxt_len_err;
         fields.bits       <= nxt_bits;
         fields.cm_err     <= nxt_cm_err;
         fields.cinfo_err  <= nxt_cinfo_err;
         fields.fcheck_err <= nxt_fcheck_err;
         fields.fdict      <= nxt_fdict;
      end
   end

endmodule

// File: hdl/hdr_status_encode.sv
//----------------------------------------
// Stage 2: turns decoded fields into format and error codes and
// holds the status word until the consumer takes it.
//----------------------------------------
`timescale 1ns/1ps

module hdr_status_encode (
   input  logic                                clk,
   input  logic                                rst_n,
   hdr_fields_if.consumer                      fields,
   input  logic                                status_ready,
   output logic                                status_valid,
   output logic [dflate_hdr_pkg::fmt_w-1:0]    status_fmt,
   output logic [dflate_hdr_pkg::err_w-1:0]    status_error,
   output logic                                status_bfinal,
   output logic [dflate_hdr_pkg::len_w-1:0]    status_len,
   output logic [dflate_hdr_pkg::bits_w-1:0]   status_bits
);

   logic                             fields_take;
   logic                             btype_bad;
   logic [dflate_hdr_pkg::err_w-1:0] nxt_error;
   logic [dflate_hdr_pkg::fmt_w-1:0] nxt_fmt;

   assign fields.ready = !status_valid || status_ready;
   assign fields_take  = fields.valid && fields.ready;

   assign btype_bad = (fields.btype == dflate_hdr_pkg::btype_reserved);

   // first error wins.
   always_comb begin
      if (fields.cm_err) begin
         nxt_error = dflate_hdr_pkg::err_cm;
      end
      else if (fields.cinfo_err) begin
         nxt_error = dflate_hdr_pkg::err_cinfo;
      end
      else if (fields.fcheck_err) begin
         nxt_error = dflate_hdr_pkg::err_fcheck;
      end
      else if (btype_bad) begin
         nxt_error = dflate_hdr_pkg::err_hdr_invalid;
      end
      else if (fields.fdict) begin
         nxt_error = dflate_hdr_pkg::err_fdict;
      end
      else if (fields.len_err) begin
         nxt_error = dflate_hdr_pkg::err_len_check;
      end
      else begin
         nxt_error = dflate_hdr_pkg::err_none;
      end
   end

   always_comb begin
      case (fields.btype)
         dflate_hdr_pkg::btype_fixed:   nxt_fmt = dflate_hdr_pkg::fmt_fixed;
         dflate_hdr_pkg::btype_dynamic: nxt_fmt = dflate_hdr_pkg::fmt_dynamic;
         default:                       nxt_fmt = dflate_hdr_pkg::fmt_stored;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_valid <= 1'b0;
      end
      else if (fields_take) begin
         status_valid <= 1'b1;
      end
      else if (status_ready) begin
         status_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fields_take) begin
         status_error <= nxt_error;
         status_bits  <= fields.bits;   // kept even on error.
         if (nxt_error == dflate_hdr_pkg::err_none) begin
            status_fmt    <= nxt_fmt;
            status_bfinal <= fields.bfinal;
            status_len    <= fields.len;
         end
         else begin
            status_fmt    <= dflate_hdr_pkg::fmt_stored;
            status_bfinal <= 1'b0;
            status_len    <= '0;
         end
      end
   end

endmodule

// File: hdl/dflate_hdr_parser.sv
//----------------------------------------
// Header parser top for zlib and raw deflate frames.
// Feed words on in_*, read one status per sof word on status_*.
//----------------------------------------
`timescale 1ns/1ps

module dflate_hdr_parser (
   input  logic                                  clk,
   input  logic                                  rst_n,

   // input word stream.
   input  logic [dflate_hdr_pkg::hdr_word_w-1:0] in_data,
   input  logic                                  in_sof,
   input  logic                                  in_zlib,    // selects framing of the sof word.
   input  logic                                  in_valid,
   output logic                                  in_ready,

   // per frame status.
   output logic                                  status_valid,
   input  logic                                  status_ready,
   output logic [dflate_hdr_pkg::fmt_w-1:0]      status_fmt,
   output logic [dflate_hdr_pkg::err_w-1:0]      status_error,
   output logic                                  status_bfinal,
   output logic [dflate_hdr_pkg::len_w-1:0]      status_len,
   output logic [dflate_hdr_pkg::bits_w-1:0]     status_bits
);

   hdr_fields_if u_fields ();

   // stage 1 decodes one header per accepted sof word.
   hdr_field_decode u_decode (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_data  (in_data),
      .in_sof   (in_sof),
      .in_zlib  (in_zlib),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .fields   (u_fields.producer)
   );

   // stage 2 applies the error priority and holds the status.
   hdr_status_encode u_encode (
      .clk           (clk),
      .rst_n         (rst_n),
      .fields        (u_fields.consumer),
      .status_ready  (status_ready),
      .status_valid  (status_valid),
      .status_fmt    (status_fmt),
      .status_error  (status_error),
      .status_bfinal (status_bfinal),
      .status_len    (status_len),
      .status_bits   (status_bits)
   );

endmodule

// File: dv/tb_hdr_model.svh
//----------------------------------------
// Reference model for the header parser testbench. Builds header
// words and predicts the status each one must produce.
//----------------------------------------
`ifndef TB_HDR_MODEL_SVH
`define TB_HDR_MODEL_SVH

typedef struct packed {
   logic [1:0]  fmt;
   logic [3:0]  err;
   logic        bfinal;
   logic [15:0] len;
   logic [6:0]  bits;
} status_t;

// CMF and FLG with a fitting FCHECK, then the first block header.
function automatic logic [63:0] build_zlib(
   input logic [3:0]  cm,
   input logic [3:0]  cinfo,
   input logic        fbad,
   input logic        fdict,
   input logic        bfinal,
   input logic [1:0]  btype,
   input logic [15:0] len,
   input logic        nbad,
   input logic [31:0] fill
);
   logic [7:0]  cmf;
   logic [7:0]  flg;
   logic [15:0] rem;
   logic [15:0] nlen;
   cmf = {cinfo, cm};
   flg = {fill[1:0], fdict, 5'd0};
   rem = {cmf, flg} % 16'd31;
   flg[4:0] = (rem == 16'd0) ? 5'd0 : 5'(16'd31 - rem);
   if (fbad) begin
      flg[4:0] = flg[4:0] + 5'd1;   // remainder becomes 1.
   end
   nlen = nbad ? (~len ^ {fill[31:17], 1'b1}) : ~len;
   return {fill[15:8], nlen, len, fill[6:2], btype, bfinal, flg, cmf};
endfunction

function automatic logic [63:0] build_raw(
   input logic        bfinal,
   input logic [1:0]  btype,
   input logic [15:0] len,
   input logic        nbad,
   input logic [31:0] fill
);
   logic [15:0] nlen;
   nlen = nbad ? (~len ^ {fill[22:8], 1'b1}) : ~len;
   return {fill[31:8], nlen, len, fill[4:0], btype, bfinal};
endfunction

function automatic status_t predict_status(input logic [63:0] w, input logic zlib);
   status_t     s;
   logic        bfinal;
   logic [1:0]  btype;
   logic [15:0] len;
   logic [15:0] nlen;
   bfinal = zlib ? w[16] : w[0];
   btype  = zlib ? w[18:17] : w[2:1];
   len    = zlib ? w[39:24] : w[23:8];
   nlen   = zlib ? w[55:40] : w[39:24];
   if (zlib) begin
      s.bits = (btype == 2'd0) ? 7'd56 : 7'd19;
   end
   else begin
      s.bits = (btype == 2'd0) ? 7'd40 : 7'd3;
   end
   // cm, cinfo, fcheck, reserved type, fdict, then nlen.
   if (zlib && w[3:0] != 4'd8) begin
      s.err = 4'd1;
   end
   else if (zlib && w[7:4] != 4'd7) begin
      s.err = 4'd2;
   end
   else if (zlib && {w[7:0], w[15:8]} % 16'd31 != 16'd0) begin
      s.err = 4'd3;
   end
   else if (btype == 2'd3) begin
      s.err = 4'd4;
   end
   else if (zlib && w[13]) begin
      s.err = 4'd5;
   end
   else if (btype == 2'd0 && nlen != ~len) begin
      s.err = 4'd6;
   end
   else begin
      s.err = 4'd0;
   end
   s.fmt    = (s.err == 4'd0 && btype != 2'd3) ? btype : 2'd0;
   s.bfinal = (s.err == 4'd0) ? bfinal : 1'b0;
   s.len    = (s.err == 4'd0 && btype == 2'd0) ? len : 16'd0;
   return s;
endfunction

`endif

// File: dv/tb_dflate_hdr_parser.sv
//----------------------------------------
// Testbench for the header parser. Random zlib and raw frames with
// payload words and back-pressure, checked against a model.
//----------------------------------------
`timescale 1ns/1ps

module tb_dflate_hdr_parser;

   localparam int clk_period   = 4;
   localparam int n_frames     = 200;
   localparam int total_frames = 4 * n_frames;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [63:0] in_data;
   logic        in_sof;
   logic        in_zlib;
   logic        in_valid;
   logic        in_ready;
   logic        status_valid;
   logic        status_ready;
   logic [1:0]  status_fmt;
   logic [3:0]  status_error;
   logic        status_bfinal;
   logic [15:0] status_len;
   logic [6:0]  status_bits;

   `include "tb_hdr_model.svh"

   logic [15:0] lfsr = 16'd12889;
   status_t     want_q[$];
   int          acc_q[$];
   int          cycle = 0;
   int          mon_errors = 0;
   int          main_errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          failed = 0;
   logic        ready_random = 1'b0;
   logic        lat_check = 1'b0;
   logic        stalled = 1'b0;
   logic [30:0] held;

   dflate_hdr_parser u_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_data       (in_data),
      .in_sof        (in_sof),
      .in_zlib       (in_zlib),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .status_valid  (status_valid),
      .status_ready  (status_ready),
      .status_fmt    (status_fmt),
      .status_error  (status_error),
      .status_bfinal (status_bfinal),
      .status_len    (status_len),
      .status_bits   (status_bits)
   );

   always #(clk_period / 2) clk = ~clk;

   function automatic logic rand_bit();
      logic b;
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], rand_bit()};
      end
      return r;
   endfunction

   function automatic logic [63:0] random_zlib(input logic faults);
      logic [4:0]  bad;
      logic [3:0]  cm;
      logic [3:0]  cinfo;
      logic [1:0]  btype;
      logic        bfinal;
      logic [15:0] len;
      logic [31:0] fill;
      bad    = 5'(rand_bits(5));
      bad    = faults ? (bad & 5'(rand_bits(5))) : 5'd0;   // each fault one in four.
      cm     = bad[0] ? 4'(rand_bits(4)) : 4'd8;
      cinfo  = bad[1] ? 4'(rand_bits(4)) : 4'd7;
      btype  = faults ? 2'(rand_bits(2)) : 2'(rand_bits(16) % 32'd3);
      bfinal = rand_bit();
      len    = 16'(rand_bits(16));
      fill   = rand_bits(32);
      return build_zlib(cm, cinfo, bad[2], bad[3], bfinal, btype, len, bad[4], fill);
   endfunction

   function automatic logic [63:0] random_raw();
      logic [1:0]  btype;
      logic        bfinal;
      logic [15:0] len;
      logic        nbad;
      logic [31:0] fill;
      btype  = 2'(rand_bits(2));
      bfinal = rand_bit();
      len    = 16'(rand_bits(16));
      nbad   = (rand_bits(2) == 32'd0);
      fill   = rand_bits(32);
      return build_raw(bfinal, btype, len, nbad, fill);
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      status_ready <= ready_random ? rand_bit() : 1'b1;
   endtask

   task automatic send_word(input logic [63:0] data, input logic sof, input logic zlib);
      in_data  <= data;
      in_sof   <= sof;
      in_zlib  <= zlib;
      in_valid <= 1'b1;
      next_cycle();
      while (!in_ready) begin
         next_cycle();
      end
      in_valid <= 1'b0;
   endtask

   task automatic send_frame(input logic [63:0] hdr, input logic zlib);
      int          n_payload;
      logic [63:0] word;
      logic        word_zlib;
      n_payload = rand_bits(2);
      send_word(hdr, 1'b1, zlib);
      for (int i = 0; i < n_payload; i++) begin
         word[63:32] = rand_bits(32);
         word[31:0]  = rand_bits(32);
         word_zlib   = rand_bit();
         send_word(word, 1'b0, word_zlib);
      end
      if (rand_bits(2) == 32'd0) begin
         next_cycle();
      end
   endtask

   // mode 0 clean zlib, 1 zlib faults, 2 raw, 3 mixed.
   task automatic run_test(input string name, input int mode);
      int   err_start;
      int   wait_cycles;
      logic zlib;
      err_start    = mon_errors + main_errors;
      ready_random = (mode != 0);
      lat_check   <= (mode == 0);
      next_cycle();
      for (int f = 0; f < n_frames; f++) begin
         zlib = (mode == 3) ? rand_bit() : (mode != 2);
         send_frame(zlib ? random_zlib(mode != 0) : random_raw(), zlib);
      end
      wait_cycles = 0;
      @(negedge clk);
      while (want_q.size() != 0 && wait_cycles < 64) begin
         next_cycle();
         @(negedge clk);
         wait_cycles++;
      end
      repeat (2) next_cycle();
      @(negedge clk);
      if (want_q.size() != 0) begin
         $display("%0d headers in test %s never produced a status", want_q.size(), name);
         main_errors++;
      end
      tests++;
      if (mon_errors + main_errors != err_start) begin
         failed++;
      end
      $display("test %s: %0d frames, %0d errors", name, n_frames,
               mon_errors + main_errors - err_start);
   endtask

   // input and status monitor.
   always @(posedge clk) begin
      status_t want;
      int      acc;
      if (stalled && {status_valid, status_fmt, status_error, status_bfinal,
                      status_len, status_bits} !== held) begin
         $display("status outputs changed while status_ready was low");
         mon_errors++;
      end
      stalled = status_valid && !status_ready;
      held    = {status_valid, status_fmt, status_error, status_bfinal, status_len, status_bits};
      if (status_valid && status_ready) begin
         if (want_q.size() == 0) begin
            $display("status transfer with no header pending");
            mon_errors++;
         end
         else begin
            want = want_q.pop_front();
            acc  = acc_q.pop_front();
            checks++;
            if (status_fmt !== want.fmt) begin
               $display("Error: status_fmt is 0x%0h, expected 0x%0h", status_fmt, want.fmt);
               mon_errors++;
            end
            if (status_error !== want.err) begin
               $display("Error: status_error is 0x%0h, expected 0x%0h", status_error, want.err);
               mon_errors++;
            end
            if (status_bfinal !== want.bfinal) begin
               $display("Error: status_bfinal is 0x%0h, expected 0x%0h", status_bfinal,
                        want.bfinal);
               mon_errors++;
            end
            if (status_len !== want.len) begin
               $display("Error: status_len is 0x%0h, expected 0x%0h", status_len, want.len);
               mon_errors++;
            end
            if (status_bits !== want.bits) begin
               $display("Error: status_bits is 0x%0h, expected 0x%0h", status_bits, want.bits);
               mon_errors++;
            end
            if (lat_check && cycle - acc != 2) begin
               $display("status came %0d cycles after its header instead of 2", cycle - acc);
               mon_errors++;
            end
         end
      end
      if (in_valid && in_ready && in_sof) begin
         want_q.push_back(predict_status(in_data, in_zlib));
         acc_q.push_back(cycle);
      end
      cycle++;
   end

   initial begin
      #(total_frames * 20 * clk_period);
      $display("watchdog expired with %0d headers still pending", want_q.size());
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      rst_n        <= 1'b0;
      in_data      <= '0;
      in_sof       <= 1'b0;
      in_zlib      <= 1'b0;
      in_valid     <= 1'b0;
      status_ready <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (status_valid !== 1'b0) begin
         $display("Error: status_valid is 0x%0h after reset, expected 0x0", status_valid);
         main_errors++;
      end
      if (in_ready !== 1'b1) begin
         $display("Error: in_ready is 0x%0h after reset, expected 0x1", in_ready);
         main_errors++;
      end
      tests++;
      if (main_errors != 0) begin
         failed++;
      end
      $display("test reset: %0d errors", main_errors);
      run_test("zlib valid", 0);
      run_test("zlib errors", 1);
      run_test("raw deflate", 2);
      run_test("mixed payload", 3);
      $display("%0d tests, %0d failed, %0d statuses checked, %0d errors", tests, failed,
               checks, mon_errors + main_errors);
      if (mon_errors + main_errors == 0) begin
         $display("TESTBENCH PASSED");
      end
      else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+dv
hdl/dflate_hdr_pkg.sv
hdl/hdr_fields_if.sv
hdl/hdr_field_decode.sv
hdl/hdr_status_encode.sv
hdl/dflate_hdr_parser.sv
dv/tb_dflate_hdr_parser.sv

// File: Makefile
# Verilator build and run of the header parser testbench.

SRCS := $(shell grep -v '^+' vlog.f) dv/tb_hdr_model.svh
BIN  := obj_dir/Vtb_dflate_hdr_parser

.PHONY: all run clean

all: run

$(BIN): $(SRCS) vlog.f
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module tb_dflate_hdr_parser -o Vtb_dflate_hdr_parser

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTBENCH PASSED'

clean:
	rm -rf obj_dir
